// ==== hw/rv_csr_pkg.sv ====
`default_nettype none

package rv_csr_pkg;

  // csr read-modify-write kind
  typedef enum logic [1:0] {
    csr_none = 2'd0,
    csr_rw   = 2'd1,
    csr_rs   = 2'd2,
    csr_rc   = 2'd3
  } csr_op_e;

  // machine csr addresses kept by the execute unit
  localparam logic [11:0] csr_mtvec    = 12'h305;
  localparam logic [11:0] csr_mscratch = 12'h340;
  localparam logic [11:0] csr_mepc     = 12'h341;
  localparam logic [11:0] csr_mcause   = 12'h342;

  // environment call from m-mode
  localparam logic [31:0] ecall_cause = 32'd11;

endpackage

`default_nettype wire

// ==== hw/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 32;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {wb_alu, wb_pc_plus4, wb_csr} wb_sel_e;

  typedef enum logic [2:0] {pc_seq, pc_jal, pc_jalr, pc_branch, pc_trap, pc_mret} pc_sel_e;

  typedef enum logic [2:0] {br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu} br_cond_e;

  typedef struct packed {
    alu_op_e             alu_op;
    wb_sel_e             wb_sel;
    pc_sel_e             pc_sel;
    br_cond_e            br_cond;
    rv_csr_pkg::csr_op_e csr_op;
    logic                a_pc;
    logic                b_imm;
    logic                reg_write;
    logic                illegal;
  } ctrl_t;

  typedef struct packed {
    logic [xlen-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
  } operands_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
  } fetch_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    ctrl_t           ctrl;
    operands_t       operands;
    logic [11:0]     csr_addr;
  } decoded_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    logic [4:0]      rd;
    logic [xlen-1:0] wdata;
    logic            wen;
    logic            trap;
    logic            illegal;
  } retire_t;

endpackage

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`default_nettype none

module inst_decoder (
  input  logic [31:0]       inst,
  output rv_isa_pkg::ctrl_t ctrl
);
  import rv_isa_pkg::*;
  import rv_csr_pkg::*;

  localparam logic [31:0] ecall_word = 32'h0000_0073;
  localparam logic [31:0] mret_word  = 32'h3020_0073;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       csr_known;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // only the four machine csrs exist
  assign csr_known = inst[31:20] inside {csr_mtvec, csr_mscratch, csr_mepc, csr_mcause};

  always_comb begin
    ctrl.alu_op    = alu_pass_b;
    ctrl.wb_sel    = wb_alu;
    ctrl.pc_sel    = pc_seq;
    ctrl.br_cond   = br_eq;
    ctrl.csr_op    = csr_none;
    ctrl.a_pc      = 1'b0;
    ctrl.b_imm     = 1'b0;
    ctrl.reg_write = 1'b0;
    ctrl.illegal   = 1'b0;

    case (opcode)
      opc_lui, opc_auipc: begin
        // lui sees rs1 forced to x0, so both are an add with the immediate
        ctrl.alu_op    = alu_add;
        ctrl.a_pc      = (opcode == opc_auipc);
        ctrl.b_imm     = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      opc_jal: begin
        ctrl.wb_sel    = wb_pc_plus4;
        ctrl.pc_sel    = pc_jal;
        ctrl.reg_write = 1'b1;
      end
      opc_jalr: begin
        ctrl.alu_op    = alu_add;
        ctrl.b_imm     = 1'b1;
        ctrl.wb_sel    = wb_pc_plus4;
        ctrl.pc_sel    = pc_jalr;
        ctrl.reg_write = 1'b1;
        ctrl.illegal   = (funct3 != 3'b000);
      end
      opc_branch: begin
        ctrl.pc_sel = pc_branch;
        case (funct3)
          3'b000:  ctrl.br_cond = br_eq;
          3'b001:  ctrl.br_cond = br_ne;
          3'b100:  ctrl.br_cond = br_lt;
          3'b101:  ctrl.br_cond = br_ge;
          3'b110:  ctrl.br_cond = br_ltu;
          3'b111:  ctrl.br_cond = br_geu;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      opc_op_imm: begin
        ctrl.b_imm     = 1'b1;
        ctrl.reg_write = 1'b1;
        case (funct3)
          3'b000: ctrl.alu_op = alu_add;
          3'b010: ctrl.alu_op = alu_slt;
          3'b011: ctrl.alu_op = alu_sltu;
          3'b100: ctrl.alu_op = alu_xor;
          3'b110: ctrl.alu_op = alu_or;
          3'b111: ctrl.alu_op = alu_and;
          3'b001: begin
            ctrl.alu_op  = alu_sll;
            ctrl.illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // shift right, funct7 picks logical or arithmetic
            ctrl.alu_op  = funct7[5] ? alu_sra : alu_srl;
            ctrl.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      opc_op: begin
        ctrl.reg_write = 1'b1;
        if (funct7 == 7'b0100000) begin
          case (funct3)
            3'b000:  ctrl.alu_op = alu_sub;
            3'b101:  ctrl.alu_op = alu_sra;
            default: ctrl.illegal = 1'b1;
          endcase
        end else if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  ctrl.alu_op = alu_add;
            3'b001:  ctrl.alu_op = alu_sll;
            3'b010:  ctrl.alu_op = alu_slt;
            3'b011:  ctrl.alu_op = alu_sltu;
            3'b100:  ctrl.alu_op = alu_xor;
            3'b101:  ctrl.alu_op = alu_srl;
            3'b110:  ctrl.alu_op = alu_or;
            default: ctrl.alu_op = alu_and;
          endcase
        end else begin
          // rv32m and anything else
          ctrl.illegal = 1'b1;
        end
      end
      opc_system: begin
        if (inst == ecall_word) begin
          ctrl.pc_sel = pc_trap;
        end else if (inst == mret_word) begin
          ctrl.pc_sel = pc_mret;
        end else begin
          ctrl.wb_sel    = wb_csr;
          ctrl.reg_write = 1'b1;
          ctrl.illegal   = !csr_known;
          case (funct3)
            3'b001:  ctrl.csr_op = csr_rw;
            3'b010:  ctrl.csr_op = csr_rs;
            3'b011:  ctrl.csr_op = csr_rc;
            default: ctrl.illegal = 1'b1;
          endcase
        end
      end
      // no data memory behind this slice
      opc_load, opc_store: ctrl.illegal = 1'b1;
      default:             ctrl.illegal = 1'b1;
    endcase

    // illegal words fall through as a plain pc + 4 with no side effects
    if (ctrl.illegal) begin
      ctrl.reg_write = 1'b0;
      ctrl.pc_sel    = pc_seq;
      ctrl.csr_op    = csr_none;
    end
  end

endmodule

`default_nettype wire

// ==== hw/imm_gen.sv ====
`default_nettype none

module imm_gen (
  input  logic [31:0]           inst,
  output rv_isa_pkg::operands_t operands
);
  import rv_isa_pkg::*;

  opcode_e opcode;

  assign opcode = opcode_e'(inst[6:0]);

  always_comb begin
    case (opcode)
      // u-type, low 12 bits zero
      opc_lui, opc_auipc: begin
        operands.imm = {inst[31:12], 12'b0};
      end
      opc_jal: begin
        operands.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      opc_branch: begin
        operands.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      opc_store: begin
        operands.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      // i-type covers jalr, op-imm, loads and system
      default: begin
        operands.imm = {{20{inst[31]}}, inst[31:20]};
      end
    endcase
  end

  // lui reads x0 so the alu computes 0 + imm
  assign operands.rs1 = (opcode == opc_lui) ? 5'd0 : inst[19:15];
  assign operands.rs2 = inst[24:20];
  assign operands.rd  = inst[11:7];

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`default_nettype none

module decode_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 inst_valid,
  output logic                 inst_ready,
  input  rv_isa_pkg::fetch_t   fetch,
  output logic                 dec_valid,
  input  logic                 dec_ready,
  input  logic                 write_back,
  output rv_isa_pkg::decoded_t decoded
);
  import rv_isa_pkg::*;

  // idle accepts, holding offers the bundle, waiting sits until writeback
  typedef enum logic [1:0] {idle, holding, waiting} state_e;

  state_e    state;
  ctrl_t     dec_ctrl;
  operands_t dec_ops;
  logic      accept;

  inst_decoder u_inst_decoder (
    .inst (fetch.inst),
    .ctrl (dec_ctrl)
  );

  imm_gen u_imm_gen (
    .inst     (fetch.inst),
    .operands (dec_ops)
  );

  assign inst_ready = (state == idle);
  assign dec_valid  = (state == holding);
  assign accept     = inst_valid && inst_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle:    if (accept) state <= holding;
        holding: if (dec_ready) state <= waiting;
        waiting: if (write_back) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // bundle is captured once per accepted word
  always_ff @(posedge clock) begin
    if (accept) begin
      decoded.pc       <= fetch.pc;
      decoded.ctrl     <= dec_ctrl;
      decoded.operands <= dec_ops;
      decoded.csr_addr <= fetch.inst[31:20];
    end
  end

  a_no_overlap: assert property (@(posedge clock) disable iff (reset)
    !(dec_valid && inst_ready));

  // execute unit only writes back the bundle it took from here
  a_wb_after_transfer: assert property (@(posedge clock) disable iff (reset)
    write_back |-> state == waiting);

endmodule

`default_nettype wire

// ==== hw/exec_unit.sv ====
`default_nettype none

module exec_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  rv_isa_pkg::decoded_t decoded,
  input  logic                 dec_valid,
  output logic                 dec_ready,
  output logic                 write_back,
  output logic                 retire_valid,
  output rv_isa_pkg::retire_t  retire
);
  import rv_isa_pkg::*;
  import rv_csr_pkg::*;

  logic [xlen-1:0] regs [1:31];
  logic [xlen-1:0] mtvec, mscratch, mepc, mcause;

  logic [xlen-1:0] rs1_val, rs2_val, op_a, op_b, alu_out;
  logic [xlen-1:0] pc_plus4, pc_target, next_pc, wdata;
  logic [xlen-1:0] csr_old, csr_new;
  logic            br_taken, reg_wen, is_trap, transfer;

  // x0 is hardwired
  assign rs1_val = (decoded.operands.rs1 == 5'd0) ? '0 : regs[decoded.operands.rs1];
  assign rs2_val = (decoded.operands.rs2 == 5'd0) ? '0 : regs[decoded.operands.rs2];

  assign op_a = decoded.ctrl.a_pc ? decoded.pc : rs1_val;
  assign op_b = decoded.ctrl.b_imm ? decoded.operands.imm : rs2_val;

  always_comb begin
    case (decoded.ctrl.alu_op)
      alu_add:  alu_out = op_a + op_b;
      alu_sub:  alu_out = op_a - op_b;
      alu_sll:  alu_out = op_a << op_b[4:0];
      alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:  alu_out = op_a ^ op_b;
      alu_srl:  alu_out = op_a >> op_b[4:0];
      alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
      alu_or:   alu_out = op_a | op_b;
      alu_and:  alu_out = op_a & op_b;
      default:  alu_out = op_b;
    endcase
  end

  always_comb begin
    case (decoded.ctrl.br_cond)
      br_eq:   br_taken = (rs1_val == rs2_val);
      br_ne:   br_taken = (rs1_val != rs2_val);
      br_lt:   br_taken = $signed(rs1_val) < $signed(rs2_val);
      br_ge:   br_taken = $signed(rs1_val) >= $signed(rs2_val);
      br_ltu:  br_taken = rs1_val < rs2_val;
      default: br_taken = rs1_val >= rs2_val;
    endcase
  end

  always_comb begin
    case (decoded.csr_addr)
      csr_mtvec:    csr_old = mtvec;
      csr_mscratch: csr_old = mscratch;
      csr_mepc:     csr_old = mepc;
      csr_mcause:   csr_old = mcause;
      default:      csr_old = '0;
    endcase
    case (decoded.ctrl.csr_op)
      csr_rs:  csr_new = csr_old | rs1_val;
      csr_rc:  csr_new = csr_old & ~rs1_val;
      default: csr_new = rs1_val;
    endcase
  end

  assign pc_plus4  = decoded.pc + 32'd4;
  assign pc_target = decoded.pc + decoded.operands.imm;

  always_comb begin
    case (decoded.ctrl.pc_sel)
      pc_jal:    next_pc = pc_target;
      pc_jalr:   next_pc = {alu_out[xlen-1:1], 1'b0};
      pc_branch: next_pc = br_taken ? pc_target : pc_plus4;
      pc_trap:   next_pc = mtvec;
      pc_mret:   next_pc = mepc;
      default:   next_pc = pc_plus4;
    endcase
    case (decoded.ctrl.wb_sel)
      wb_pc_plus4: wdata = pc_plus4;
      wb_csr:      wdata = csr_old;
      default:     wdata = alu_out;
    endcase
  end

  assign reg_wen  = decoded.ctrl.reg_write && (decoded.operands.rd != 5'd0);
  assign is_trap  = (decoded.ctrl.pc_sel == pc_trap);
  // busy only during the retire cycle
  assign dec_ready  = !retire_valid;
  assign transfer   = dec_valid && dec_ready;
  assign write_back = retire_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else if (transfer) begin
      if (reg_wen) regs[decoded.operands.rd] <= wdata;
      if (decoded.ctrl.csr_op != csr_none) begin
        case (decoded.csr_addr)
          csr_mtvec:    mtvec <= csr_new;
          csr_mscratch: mscratch <= csr_new;
          csr_mepc:     mepc <= csr_new;
          default:      mcause <= csr_new;
        endcase
      end
      if (is_trap) begin
        mepc   <= decoded.pc;
        mcause <= ecall_cause;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) retire_valid <= 1'b0;
    else       retire_valid <= transfer;
  end

  always_ff @(posedge clock) begin
    if (transfer) begin
      retire.pc      <= decoded.pc;
      retire.next_pc <= next_pc;
      retire.rd      <= decoded.operands.rd;
      retire.wdata   <= wdata;
      retire.wen     <= reg_wen;
      retire.trap    <= is_trap;
      retire.illegal <= decoded.ctrl.illegal;
    end
  end

  a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
    retire_valid |-> !(retire.wen && retire.rd == 5'd0));

endmodule

`default_nettype wire

// ==== hw/rv_exec_top.sv ====
`default_nettype none

module rv_exec_top (
  input  logic                clock,
  input  logic                reset,
  input  logic                inst_valid,
  output logic                inst_ready,
  input  rv_isa_pkg::fetch_t  fetch,
  output logic                retire_valid,
  output rv_isa_pkg::retire_t retire
);
  import rv_isa_pkg::*;

  decoded_t decoded;
  logic     dec_valid;
  logic     dec_ready;
  logic     write_back;

  decode_stage u_decode (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .fetch      (fetch),
    .dec_valid  (dec_valid),
    .dec_ready  (dec_ready),
    .write_back (write_back),
    .decoded    (decoded)
  );

  exec_unit u_exec (
    .clock        (clock),
    .reset        (reset),
    .decoded      (decoded),
    .dec_valid    (dec_valid),
    .dec_ready    (dec_ready),
    .write_back   (write_back),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

`default_nettype wire

// ==== tests/tb_checker.sv ====
`default_nettype none

module tb_checker (
  input  logic                clock,
  input  logic                reset,
  input  logic                inst_valid,
  input  logic                inst_ready,
  input  rv_isa_pkg::fetch_t  fetch,
  input  logic                retire_valid,
  input  rv_isa_pkg::retire_t retire,
  output int                  errors,
  output int                  checks
);
  import rv_isa_pkg::*;
  import rv_csr_pkg::*;

  logic [31:0] model_regs [32];
  // mtvec, mscratch, mepc, mcause
  logic [31:0] model_csr [4];
  retire_t     expected;
  logic        pending;
  logic        ready_due;
  logic        held;
  logic        seen_accept;
  int          pending_age;
  int          gap;

  function automatic int csr_index(input logic [11:0] addr);
    case (addr)
      csr_mtvec:    return 0;
      csr_mscratch: return 1;
      csr_mepc:     return 2;
      csr_mcause:   return 3;
      default:      return -1;
    endcase
  endfunction

  // rv32i integer ops by funct3, alt selects sub and sra
  function automatic logic [31:0] alu(input logic [31:0] a, input logic [31:0] b,
                                      input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end else begin
          return a >> b[4:0];
        end
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic retire_t predict(input logic [31:0] inst, input logic [31:0] pc);
    retire_t     r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic        wb;
    logic        bad;
    logic        taken;
    f3    = inst[14:12];
    f7    = inst[31:25];
    a     = model_regs[inst[19:15]];
    b     = model_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    imm_u = {inst[31:12], 12'b0};
    wb    = 1'b0;
    bad   = 1'b0;
    taken = 1'b0;
    r         = '0;
    r.pc      = pc;
    r.next_pc = pc + 32'd4;
    r.rd      = inst[11:7];
    case (inst[6:0])
      7'b0110111: begin
        r.wdata = imm_u;
        wb      = 1'b1;
      end
      7'b0010111: begin
        r.wdata = pc + imm_u;
        wb      = 1'b1;
      end
      7'b1101111: begin
        r.wdata   = pc + 32'd4;
        r.next_pc = pc + imm_j;
        wb        = 1'b1;
      end
      7'b1100111: begin
        r.wdata   = pc + 32'd4;
        r.next_pc = (a + imm_i) & ~32'd1;
        wb        = 1'b1;
        bad       = (f3 != 3'b000);
      end
      7'b1100011: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          3'b111:  taken = (a >= b);
          default: bad = 1'b1;
        endcase
        if (taken) r.next_pc = pc + imm_b;
      end
      7'b0010011: begin
        bad = (f3 == 3'b001 && f7 != 7'h00) ||
              (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
        r.wdata = alu(a, imm_i, f3, (f3 == 3'b101) && f7[5]);
        wb      = 1'b1;
      end
      7'b0110011: begin
        bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
        r.wdata = alu(a, b, f3, f7[5]);
        wb      = 1'b1;
      end
      7'b1110011: begin
        if (inst == 32'h0000_0073) begin
          r.trap    = 1'b1;
          r.next_pc = model_csr[0];
        end else if (inst == 32'h3020_0073) begin
          r.next_pc = model_csr[2];
        end else if (f3 inside {3'b001, 3'b010, 3'b011} && csr_index(inst[31:20]) >= 0) begin
          // csr instructions hand the old value to rd
          r.wdata = model_csr[csr_index(inst[31:20])];
          wb      = 1'b1;
        end else begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      r.next_pc = pc + 32'd4;
      wb        = 1'b0;
    end
    r.illegal = bad;
    r.wen     = wb && (inst[11:7] != 5'd0);
    return r;
  endfunction

  // csr writes read rs1 before the register write lands
  task automatic commit_model(input logic [31:0] inst, input logic [31:0] pc,
                              input retire_t exp);
    int          idx;
    logic [31:0] src;
    idx = csr_index(inst[31:20]);
    src = model_regs[inst[19:15]];
    if (exp.trap) begin
      model_csr[2] = pc;
      model_csr[3] = ecall_cause;
    end else if (inst[6:0] == 7'b1110011 && !exp.illegal && idx >= 0) begin
      case (inst[13:12])
        2'b01:   model_csr[idx] = src;
        2'b10:   model_csr[idx] = model_csr[idx] | src;
        default: model_csr[idx] = model_csr[idx] & ~src;
      endcase
    end
    if (exp.wen) model_regs[exp.rd] = exp.wdata;
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want) begin
      $display("FAILED %s: got %08h, expected %08h (pc %08h)", name, got, want, expected.pc);
      errors++;
    end
  endtask

  task automatic compare_retire();
    if (!pending) begin
      $display("retire pulse seen with no instruction in flight");
      errors++;
      return;
    end
    pending = 1'b0;
    check_field("retire.pc", retire.pc, expected.pc);
    check_field("retire.next_pc", retire.next_pc, expected.next_pc);
    check_field("retire.rd", 32'(retire.rd), 32'(expected.rd));
    check_field("retire.wen", 32'(retire.wen), 32'(expected.wen));
    check_field("retire.trap", 32'(retire.trap), 32'(expected.trap));
    check_field("retire.illegal", 32'(retire.illegal), 32'(expected.illegal));
    // wdata only means something with a register write
    if (expected.wen) begin
      check_field("retire.wdata", retire.wdata, expected.wdata);
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      foreach (model_regs[i]) model_regs[i] = '0;
      foreach (model_csr[i]) model_csr[i] = '0;
      errors      = 0;
      checks      = 0;
      pending     = 1'b0;
      ready_due   = 1'b0;
      seen_accept = 1'b0;
      held        = 1'b0;
      gap         = 0;
      pending_age = 0;
    end else begin
      gap++;
      if (!inst_valid) held = 1'b0;
      if (ready_due && !inst_ready) begin
        $display("inst_ready did not return one cycle after the retire pulse");
        errors++;
      end
      ready_due = retire_valid;
      if (retire_valid) begin
        compare_retire();
      end else if (pending) begin
        pending_age++;
        if (pending_age > 10) begin
          $display("instruction at pc %08h did not retire within 10 cycles", expected.pc);
          errors++;
          pending = 1'b0;
        end
      end
      if (inst_valid && inst_ready) begin
        if (seen_accept && held && gap != 3) begin
          $display("accepts were %0d cycles apart with inst_valid held, not 3", gap);
          errors++;
        end
        if (pending) begin
          $display("new instruction accepted before the previous one retired");
          errors++;
        end
        expected = predict(fetch.inst, fetch.pc);
        commit_model(fetch.inst, fetch.pc, expected);
        pending     = 1'b1;
        pending_age = 0;
        gap         = 0;
        held        = 1'b1;
        seen_accept = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_top.sv ====
`default_nettype none

module tb_top;
  import rv_isa_pkg::*;
  import rv_csr_pkg::*;

  localparam int num_random = 600;
  localparam int max_wait   = 20;

  logic        clock;
  logic        reset;
  logic        inst_valid;
  logic        inst_ready;
  fetch_t      fetch;
  logic        retire_valid;
  retire_t     retire;
  int          errors;
  int          checks;
  int          timeouts;
  int          seed;
  logic [31:0] pc;
  logic [31:0] word;
  logic [31:0] directed [$];

  rv_exec_top i_dut (.*);

  tb_checker u_checker (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // one random word from a mix of kept, illegal and raw encodings
  task automatic make_inst(output logic [31:0] inst);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [11:0] csr;
    int          kind;
    kind = int'({$random(seed)} % 32'd12);
    r    = $random(seed);
    f3   = (r[13:12] == 2'b00) ? 3'b001 : {1'b0, r[13:12]};
    case (r[1:0])
      2'd0:    csr = csr_mtvec;
      2'd1:    csr = csr_mscratch;
      2'd2:    csr = csr_mepc;
      default: csr = csr_mcause;
    endcase
    case (kind)
      0:       inst = {1'b0, r[30], 5'b0, r[24:7], 7'b0110011};
      1: begin
        if (r[13:12] == 2'b01) begin
          // slli, srli, srai need a clean funct7
          inst = {1'b0, r[30] & r[14], 5'b0, r[24:7], 7'b0010011};
        end else begin
          inst = {r[31:7], 7'b0010011};
        end
      end
      2:       inst = {r[31:7], 7'b0110111};
      3:       inst = {r[31:7], 7'b0010111};
      4:       inst = {r[31:7], 7'b1101111};
      5:       inst = {r[31:15], 3'b000, r[11:7], 7'b1100111};
      6:       inst = {r[31:7], 7'b1100011};
      7:       inst = {csr, r[19:15], f3, r[11:7], 7'b1110011};
      8:       inst = {r[31:7], r[2] ? 7'b0000011 : 7'b0100011};
      9:       inst = 32'h0000_0073;
      10:      inst = 32'h3020_0073;
      default: inst = r;
    endcase
  endtask

  // inst_valid stays high, so the next word waits for inst_ready
  task automatic issue(input logic [31:0] inst);
    int wait_cycles;
    if (timeouts != 0) return;
    fetch.pc    = pc;
    fetch.inst  = inst;
    inst_valid  = 1'b1;
    wait_cycles = 0;
    while (!inst_ready) begin
      @(negedge clock);
      wait_cycles++;
      if (wait_cycles > max_wait) begin
        $display("inst_ready stayed low for %0d cycles at pc %08h", max_wait, pc);
        timeouts++;
        return;
      end
    end
    @(negedge clock);
    wait_cycles = 0;
    while (!retire_valid) begin
      @(negedge clock);
      wait_cycles++;
      if (wait_cycles > max_wait) begin
        $display("no retire pulse within %0d cycles for pc %08h", max_wait, pc);
        timeouts++;
        return;
      end
    end
    pc = retire.next_pc;
  endtask

  initial begin
    seed       = 67;
    timeouts   = 0;
    reset      = 1'b1;
    inst_valid = 1'b0;
    fetch      = '0;
    pc         = 32'h0000_1000;
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // csr access, trap entry and return, x0 writes, jumps, then memory ops
    directed = '{
      i_type(12'h400, 5'd0, 3'b000, 5'd1, 7'h13),
      i_type(csr_mtvec, 5'd1, 3'b001, 5'd2, 7'h73),
      i_type(12'hfff, 5'd0, 3'b000, 5'd3, 7'h13),
      i_type(csr_mscratch, 5'd3, 3'b010, 5'd4, 7'h73),
      i_type(csr_mscratch, 5'd1, 3'b011, 5'd5, 7'h73),
      i_type(csr_mepc, 5'd1, 3'b001, 5'd6, 7'h73),
      i_type(csr_mcause, 5'd3, 3'b010, 5'd0, 7'h73),
      32'h0000_0073,
      i_type(csr_mepc, 5'd0, 3'b010, 5'd7, 7'h73),
      i_type(csr_mcause, 5'd0, 3'b010, 5'd8, 7'h73),
      32'h3020_0073,
      i_type(12'h005, 5'd3, 3'b000, 5'd0, 7'h13),
      {7'b0, 5'd0, 5'd0, 3'b000, 5'd9, 7'h33},
      i_type(12'h003, 5'd1, 3'b000, 5'd10, 7'h67),
      {1'b0, 10'd4, 1'b0, 8'd0, 5'd11, 7'h6f},
      {7'b0, 5'd0, 5'd0, 3'b000, 4'b1000, 1'b0, 7'h63},
      i_type(12'h000, 5'd1, 3'b010, 5'd12, 7'h03),
      {7'b0, 5'd1, 5'd1, 3'b010, 5'd0, 7'h23}
    };
    foreach (directed[i]) begin
      issue(directed[i]);
    end

    for (int i = 0; i < num_random; i++) begin
      make_inst(word);
      issue(word);
    end

    // let the checker see the last retire pulse
    @(posedge clock);
    @(negedge clock);
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (timeouts != 0 || errors != 0) begin
      $display("Test failed");
    end else begin
      $display("Test passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
hw/rv_csr_pkg.sv
hw/rv_isa_pkg.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/decode_stage.sv
hw/exec_unit.sv
hw/rv_exec_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_exec_top testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f files.f -o sim_tb_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
